// ==== all.f ====
+incdir+dv
src/rob_pkg.sv
src/rob_head_if.sv
src/rob_queue.sv
src/squash_tracker.sv
src/commit_ctrl.sv
src/rob_top.sv
dv/rob_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := rob_tb
RTL_TOP    := rob_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/rob_model.svh ====
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

// one live instruction, oldest at the front of the queue
typedef struct {
    logic [IDX_W-1:0]    idx;
    rob_pkg::rob_entry_t ent;
    bit                  done;
} slot_t;

typedef enum logic [1:0] {
    md_normal,
    md_mis_sq,
    md_trap,
    md_exc_sq
} mode_e;

slot_t                       mq[$];
logic [IDX_W-1:0]            m_tail;
mode_e                       mode;
rob_pkg::squash_kind_e       r_kind;
logic [IDX_W-1:0]            r_idx;
logic [rob_pkg::XLEN-1:0]    r_npc;
logic                        r_taken;
logic [rob_pkg::CAUSE_W-1:0] r_cause;
logic [rob_pkg::XLEN-1:0]    sq_pc;
logic                        sq_taken;
logic                        sq_branch;
logic [rob_pkg::XLEN-1:0]    tr_epc;
logic [rob_pkg::CAUSE_W-1:0] tr_cause;
int                          exp_nret;
bit                          exp_exc;
bit                          exp_mis;
bit                          exp_can;

function automatic void model_clear();
    mq.delete();
    m_tail = '0;
    mode   = md_normal;
    r_kind = rob_pkg::sq_none;
endfunction

function automatic int pos_of(logic [IDX_W-1:0] idx);
    foreach (mq[i]) begin
        if (mq[i].idx == idx) begin
            return i;
        end
    end
    return -1;
endfunction

// retire count for this cycle, stopping at the first unfinished or excepting entry
function automatic void predict_retire();
    exp_nret = 0;
    exp_exc  = 0;
    exp_mis  = 0;
    exp_can  = (mode == md_normal) && ((DEPTH - mq.size()) >= RW);
    if (mode != md_normal) begin
        return;
    end
    for (int k = 0; k < CW && k < mq.size(); k++) begin
        if (!mq[k].done) begin
            break;
        end
        if (r_kind != rob_pkg::sq_none && mq[k].idx == r_idx) begin
            if (r_kind == rob_pkg::sq_except) begin
                exp_exc = 1;
            end else begin
                exp_mis  = 1;
                exp_nret = k + 1;
            end
            break;
        end
        exp_nret = k + 1;
    end
endfunction

// state for the next cycle, from the current state and this cycle's inputs
function automatic void model_step();
    int    p_br;
    int    p_exc;
    int    p;
    bit    take_exc;
    slot_t s;
    if (mode == md_mis_sq || mode == md_exc_sq) begin
        model_clear();
        return;
    end
    if (mode == md_trap) begin
        sq_pc     = trap_vec;
        sq_taken  = 0;
        sq_branch = 0;
        mode      = md_exc_sq;
        return;
    end
    if (exp_exc) begin
        tr_epc   = mq[exp_nret].ent.pc;
        tr_cause = r_cause;
        mode     = md_trap;
    end
    if (exp_mis) begin
        sq_pc     = r_npc;
        sq_taken  = r_taken;
        sq_branch = 1;
        mode      = md_mis_sq;
    end
    // ages taken against the queue before this cycle's retirement
    p_br     = br_vld ? pos_of(br_idx) : -1;
    p_exc    = exc_vld ? pos_of(exc_idx) : -1;
    take_exc = exc_vld && (!br_vld || p_exc < p_br);
    p        = take_exc ? p_exc : p_br;
    if ((br_vld || exc_vld) && (r_kind == rob_pkg::sq_none || p < pos_of(r_idx))) begin
        r_kind  = take_exc ? rob_pkg::sq_except : rob_pkg::sq_mispred;
        r_idx   = take_exc ? exc_idx : br_idx;
        r_npc   = br_npc;
        r_taken = br_taken;
        r_cause = exc_cause;
    end
    for (int k = 0; k < CN; k++) begin
        p = pos_of(fu_idx[k]);
        if (fu_fin[k] && p >= 0) begin
            s      = mq[p];
            s.done = 1;
            mq[p]  = s;
        end
    end
    for (int k = 0; k < exp_nret; k++) begin
        void'(mq.pop_front());
    end
    if (enq_vld && exp_can) begin
        for (int k = 0; k < RW; k++) begin
            if (enq_req[k]) begin
                s.idx  = m_tail;
                s.ent  = enq_entry[k];
                s.done = enq_entry[k].done_on_insert;
                mq.push_back(s);
                m_tail = m_tail + 1'b1;
            end
        end
    end
endfunction

`endif

// ==== dv/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb;

    localparam int DEPTH  = 16;
    localparam int RW     = 2;
    localparam int CW     = 2;
    localparam int CN     = 3;
    localparam int IDX_W  = $clog2(DEPTH) + 1;
    localparam int CYCLES = 4000;

    logic                        clk;
    logic                        rst;
    logic                        enq_vld;
    logic [RW-1:0]               enq_req;
    rob_pkg::rob_entry_t         enq_entry [RW];
    logic                        can_enq;
    logic [IDX_W-1:0]            alloc_idx [RW];
    logic [CN-1:0]               fu_fin;
    logic [IDX_W-1:0]            fu_idx [CN];
    logic                        br_vld;
    logic [IDX_W-1:0]            br_idx;
    logic [rob_pkg::XLEN-1:0]    br_npc;
    logic                        br_taken;
    logic                        exc_vld;
    logic [IDX_W-1:0]            exc_idx;
    logic [rob_pkg::CAUSE_W-1:0] exc_cause;
    logic [rob_pkg::XLEN-1:0]    trap_vec;
    logic [CW-1:0]               commit_vld;
    rob_pkg::commit_info_t       commit_info [CW];
    logic                        trap_vld;
    logic [rob_pkg::XLEN-1:0]    trap_epc;
    logic [rob_pkg::CAUSE_W-1:0] trap_cause;
    logic                        squash_vld;
    logic [rob_pkg::XLEN-1:0]    squash_pc;
    logic                        squash_taken;
    logic                        squash_due;

    int n_mismatch;
    int n_other;
    int n_commit;
    int n_mis;
    int n_trap;
    bit drain;

    `include "rob_model.svh"

    rob_top dut (
        .i_clk                  (clk),
        .rst                    (rst),
        .i_enq_vld              (enq_vld),
        .i_enq_req              (enq_req),
        .i_enq_entry            (enq_entry),
        .o_can_enq              (can_enq),
        .o_alloc_idx            (alloc_idx),
        .i_fu_finished          (fu_fin),
        .i_fu_idx               (fu_idx),
        .i_br_vld               (br_vld),
        .i_br_idx               (br_idx),
        .i_br_npc               (br_npc),
        .i_br_taken             (br_taken),
        .i_exc_vld              (exc_vld),
        .i_exc_idx              (exc_idx),
        .i_exc_cause            (exc_cause),
        .i_trap_vec             (trap_vec),
        .o_commit_vld           (commit_vld),
        .o_commit_info          (commit_info),
        .o_trap_vld             (trap_vld),
        .o_trap_epc             (trap_epc),
        .o_trap_cause           (trap_cause),
        .o_squash_vld           (squash_vld),
        .o_squash_pc            (squash_pc),
        .o_squash_taken         (squash_taken),
        .o_squash_due_to_branch (squash_due)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit in case the stimulus loop stalls
    initial begin
        #100000;
        $display("timeout: simulation did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            n_mismatch++;
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    function automatic rob_pkg::commit_info_t info_of(rob_pkg::rob_entry_t e);
        rob_pkg::commit_info_t c;
        c.has_rd   = e.has_rd;
        c.lrd      = e.lrd;
        c.prd      = e.prd;
        c.prev_prd = e.prev_prd;
        return c;
    endfunction

    task automatic drive_inputs();
        int open_pos[$];
        int n;
        enq_vld  = 1'b0;
        enq_req  = '0;
        fu_fin   = '0;
        br_vld   = 1'b0;
        exc_vld  = 1'b0;
        trap_vec = $urandom;
        br_npc   = $urandom;
        br_taken = $urandom_range(0, 1);
        exc_cause = $urandom;
        for (int k = 0; k < RW; k++) begin
            enq_entry[k].pc             = $urandom;
            enq_entry[k].has_rd         = $urandom_range(0, 1);
            enq_entry[k].lrd            = $urandom;
            enq_entry[k].prd            = $urandom;
            enq_entry[k].prev_prd       = $urandom;
            enq_entry[k].done_on_insert = ($urandom_range(0, 3) == 0);
        end
        if (mode != md_normal) begin
            // offered but must not be taken
            enq_vld = $urandom_range(0, 1);
            enq_req = '1;
            return;
        end
        if (!drain && $urandom_range(0, 9) < 7) begin
            n       = $urandom_range(1, RW);
            enq_vld = 1'b1;
            enq_req = RW'((1 << n) - 1);
        end
        foreach (mq[i]) begin
            if (!mq[i].done) begin
                open_pos.push_back(i);
            end
        end
        if (open_pos.size() == 0) begin
            return;
        end
        for (int k = 0; k < CN; k++) begin
            if (drain || $urandom_range(0, 9) < 4) begin
                fu_fin[k] = 1'b1;
                fu_idx[k] = mq[open_pos[$urandom_range(0, open_pos.size() - 1)]].idx;
            end
        end
        if (!drain && $urandom_range(0, 15) == 0) begin
            br_vld = 1'b1;
            br_idx = mq[open_pos[$urandom_range(0, open_pos.size() - 1)]].idx;
        end
        if (!drain && $urandom_range(0, 23) == 0) begin
            exc_vld = 1'b1;
            exc_idx = mq[open_pos[$urandom_range(0, open_pos.size() - 1)]].idx;
        end
    endtask

    task automatic compare_outputs();
        predict_retire();
        check_eq("backpressure can_enq", 64'(exp_can), 64'(can_enq));
        for (int k = 0; k < RW; k++) begin
            check_eq("backpressure alloc_idx", 64'(IDX_W'(m_tail + k)), 64'(alloc_idx[k]));
        end
        check_eq("in_order commit_vld", 64'((1 << exp_nret) - 1), 64'(commit_vld));
        for (int k = 0; k < exp_nret; k++) begin
            check_eq("in_order commit_info", 64'(info_of(mq[k].ent)), 64'(commit_info[k]));
        end
        n_commit += exp_nret;
        check_eq("exception trap_vld", 64'(mode == md_trap), 64'(trap_vld));
        if (mode == md_trap) begin
            check_eq("exception trap_epc", 64'(tr_epc), 64'(trap_epc));
            check_eq("exception trap_cause", 64'(tr_cause), 64'(trap_cause));
            n_trap++;
        end
        check_eq("squash squash_vld", 64'(mode == md_mis_sq || mode == md_exc_sq),
                 64'(squash_vld));
        if (mode == md_mis_sq || mode == md_exc_sq) begin
            check_eq("squash squash_pc", 64'(sq_pc), 64'(squash_pc));
            check_eq("squash squash_taken", 64'(sq_taken), 64'(squash_taken));
            check_eq("squash due_to_branch", 64'(sq_branch), 64'(squash_due));
            if (mode == md_mis_sq) begin
                n_mis++;
            end
        end
    endtask

    // inputs after the edge, checks at the falling edge
    task automatic run_cycle();
        drive_inputs();
        @(negedge clk);
        compare_outputs();
        model_step();
        @(posedge clk);
        #1;
    endtask

    initial begin
        int seed_val;
        int wait_cnt;
        seed_val   = $urandom(32'h3f76);
        n_mismatch = 0;
        n_other    = 0;
        n_commit   = 0;
        n_mis      = 0;
        n_trap     = 0;
        drain      = 0;
        rst        = 1'b1;
        enq_vld    = 1'b0;
        enq_req    = '0;
        fu_fin     = '0;
        br_vld     = 1'b0;
        br_idx     = '0;
        br_npc     = '0;
        br_taken   = 1'b0;
        exc_vld    = 1'b0;
        exc_idx    = '0;
        exc_cause  = '0;
        trap_vec   = '0;
        for (int k = 0; k < RW; k++) begin
            enq_entry[k] = '0;
        end
        for (int k = 0; k < CN; k++) begin
            fu_idx[k] = '0;
        end
        model_clear();
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            #1;
            check_eq("reset commit_vld", 64'(0), 64'(commit_vld));
            check_eq("reset trap_vld", 64'(0), 64'(trap_vld));
            check_eq("reset squash_vld", 64'(0), 64'(squash_vld));
            check_eq("reset can_enq", 64'(1), 64'(can_enq));
        end
        rst = 1'b0;
        for (int c = 0; c < CYCLES; c++) begin
            run_cycle();
        end
        drain    = 1;
        wait_cnt = 0;
        while (!(mq.size() == 0 && mode == md_normal) && wait_cnt < 300) begin
            run_cycle();
            wait_cnt++;
        end
        if (mq.size() != 0 || mode != md_normal) begin
            n_other++;
            $display("queue did not drain within 300 cycles");
        end
        if (n_mis == 0 || n_trap == 0 || n_commit == 0) begin
            n_other++;
            $display("random run never reached a commit, a mispredict and a trap");
        end
        $display("errors: %0d mismatches, %0d other (%0d commits, %0d mispredicts, %0d traps)",
                 n_mismatch, n_other, n_commit, n_mis, n_trap);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== src/rob_top.sv ====
`timescale 1ns/1ps

module rob_top #(
    parameter int DEPTH        = 16,
    parameter int RENAME_WIDTH = 2,
    parameter int COMMIT_WIDTH = 2,
    parameter int COMPLETE_NUM = 3
) (
    input  logic                        i_clk,
    input  logic                        rst,
    input  logic                        i_enq_vld,
    input  logic [RENAME_WIDTH-1:0]     i_enq_req,
    input  rob_pkg::rob_entry_t         i_enq_entry [RENAME_WIDTH],
    output logic                        o_can_enq,
    output logic [$clog2(DEPTH):0]      o_alloc_idx [RENAME_WIDTH],
    input  logic [COMPLETE_NUM-1:0]     i_fu_finished,
    input  logic [$clog2(DEPTH):0]      i_fu_idx [COMPLETE_NUM],
    input  logic                        i_br_vld,
    input  logic [$clog2(DEPTH):0]      i_br_idx,
    input  logic [rob_pkg::XLEN-1:0]    i_br_npc,
    input  logic                        i_br_taken,
    input  logic                        i_exc_vld,
    input  logic [$clog2(DEPTH):0]      i_exc_idx,
    input  logic [rob_pkg::CAUSE_W-1:0] i_exc_cause,
    input  logic [rob_pkg::XLEN-1:0]    i_trap_vec,
    output logic [COMMIT_WIDTH-1:0]     o_commit_vld,
    output rob_pkg::commit_info_t       o_commit_info [COMMIT_WIDTH],
    output logic                        o_trap_vld,
    output logic [rob_pkg::XLEN-1:0]    o_trap_epc,
    output logic [rob_pkg::CAUSE_W-1:0] o_trap_cause,
    output logic                        o_squash_vld,
    output logic [rob_pkg::XLEN-1:0]    o_squash_pc,
    output logic                        o_squash_taken,
    output logic                        o_squash_due_to_branch
);

    logic                        stall;
    logic                        flush;
    rob_pkg::squash_kind_e       req_kind;
    logic [$clog2(DEPTH):0]      req_idx;
    logic [rob_pkg::XLEN-1:0]    req_npc;
    logic                        req_taken;
    logic [rob_pkg::CAUSE_W-1:0] req_cause;

    rob_head_if #(
        .COMMIT_WIDTH (COMMIT_WIDTH),
        .DEPTH        (DEPTH),
        .payload_t    (rob_pkg::rob_entry_t)
    ) u_head_if ();

    rob_queue #(
        .DEPTH        (DEPTH),
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMPLETE_NUM (COMPLETE_NUM),
        .COMMIT_WIDTH (COMMIT_WIDTH),
        .payload_t    (rob_pkg::rob_entry_t)
    ) u_queue (
        .clk           (i_clk),
        .rst           (rst),
        .i_flush       (flush),
        .i_enq_vld     (i_enq_vld),
        .i_enq_req     (i_enq_req),
        .i_enq_entry   (i_enq_entry),
        .i_stall       (stall),
        .o_can_enq     (o_can_enq),
        .o_alloc_idx   (o_alloc_idx),
        .i_fu_finished (i_fu_finished),
        .i_fu_idx      (i_fu_idx),
        .head          (u_head_if.queue_side)
    );

    squash_tracker #(
        .DEPTH (DEPTH)
    ) u_tracker (
        .clk         (i_clk),
        .rst         (rst),
        .i_flush     (flush),
        .i_br_vld    (i_br_vld),
        .i_br_idx    (i_br_idx),
        .i_br_npc    (i_br_npc),
        .i_br_taken  (i_br_taken),
        .i_exc_vld   (i_exc_vld),
        .i_exc_idx   (i_exc_idx),
        .i_exc_cause (i_exc_cause),
        .head        (u_head_if.observer),
        .o_req_kind  (req_kind),
        .o_req_idx   (req_idx),
        .o_req_npc   (req_npc),
        .o_req_taken (req_taken),
        .o_req_cause (req_cause)
    );

    commit_ctrl #(
        .DEPTH        (DEPTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_ctrl (
        .clk                    (i_clk),
        .rst                    (rst),
        .head                   (u_head_if.ctrl_side),
        .i_req_kind             (req_kind),
        .i_req_idx              (req_idx),
        .i_req_npc              (req_npc),
        .i_req_taken            (req_taken),
        .i_req_cause            (req_cause),
        .i_trap_vec             (i_trap_vec),
        .o_stall                (stall),
        .o_flush                (flush),
        .o_commit_vld           (o_commit_vld),
        .o_commit_info          (o_commit_info),
        .o_trap_vld             (o_trap_vld),
        .o_trap_epc             (o_trap_epc),
        .o_trap_cause           (o_trap_cause),
        .o_squash_vld           (o_squash_vld),
        .o_squash_pc            (o_squash_pc),
        .o_squash_taken         (o_squash_taken),
        .o_squash_due_to_branch (o_squash_due_to_branch)
    );

endmodule

// ==== src/commit_ctrl.sv ====
`timescale 1ns/1ps

module commit_ctrl #(
    parameter int DEPTH        = 16,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                        clk,
    input  logic                        rst,
    rob_head_if.ctrl_side               head,
    input  rob_pkg::squash_kind_e       i_req_kind,
    input  logic [$clog2(DEPTH):0]      i_req_idx,
    input  logic [rob_pkg::XLEN-1:0]    i_req_npc,
    input  logic                        i_req_taken,
    input  logic [rob_pkg::CAUSE_W-1:0] i_req_cause,
    input  logic [rob_pkg::XLEN-1:0]    i_trap_vec,
    output logic                        o_stall,
    output logic                        o_flush,
    output logic [COMMIT_WIDTH-1:0]     o_commit_vld,
    output rob_pkg::commit_info_t       o_commit_info [COMMIT_WIDTH],
    output logic                        o_trap_vld,
    output logic [rob_pkg::XLEN-1:0]    o_trap_epc,
    output logic [rob_pkg::CAUSE_W-1:0] o_trap_cause,
    output logic                        o_squash_vld,
    output logic [rob_pkg::XLEN-1:0]    o_squash_pc,
    output logic                        o_squash_taken,
    output logic                        o_squash_due_to_branch
);

    typedef enum logic {
        st_normal,
        st_trap
    } state_e;

    state_e                      state_q;
    logic                        squash_q;
    logic                        trap_q;
    logic [rob_pkg::XLEN-1:0]    epc_q;
    logic [rob_pkg::CAUSE_W-1:0] cause_q;
    logic [rob_pkg::XLEN-1:0]    sq_pc_q;
    logic                        sq_taken_q;
    logic                        sq_branch_q;

    logic [COMMIT_WIDTH-1:0]  match;
    logic [COMMIT_WIDTH-1:0]  can_retire;
    logic                     busy;
    logic                     is_exc;
    logic                     is_mis;
    logic                     has_exc;
    logic                     has_mis;
    logic [rob_pkg::XLEN-1:0] exc_pc;

    assign busy   = squash_q || (state_q == st_trap);
    assign is_exc = (i_req_kind == rob_pkg::sq_except);
    assign is_mis = (i_req_kind == rob_pkg::sq_mispred);

    always_comb begin
        logic chain;
        chain  = 1'b1;
        exc_pc = head.head_data[0].pc;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            match[k] = head.head_vld[k] && (head.head_idx[k] == i_req_idx)
                    && (i_req_kind != rob_pkg::sq_none);
            // an excepting entry stays, everything behind a mispredict stays
            chain = chain && head.head_vld[k] && !(is_exc && match[k]);
            can_retire[k] = chain;
            chain = chain && !(is_mis && match[k]);
            if (match[k]) begin
                exc_pc = head.head_data[k].pc;
            end
        end
    end

    assign has_exc = is_exc && (|match) && !busy;
    assign has_mis = is_mis && (|match) && !busy;

    assign head.retire  = busy ? '0 : can_retire;
    assign o_commit_vld = head.retire;

    for (genvar k = 0; k < COMMIT_WIDTH; k++) begin : g_info
        assign o_commit_info[k] = '{
            has_rd:   head.head_data[k].has_rd,
            lrd:      head.head_data[k].lrd,
            prd:      head.head_data[k].prd,
            prev_prd: head.head_data[k].prev_prd
        };
    end

    // exception: commit, then trap, then squash; mispredict squashes right away
    always_ff @(posedge clk) begin
        if (rst || squash_q) begin
            state_q  <= st_normal;
            squash_q <= 1'b0;
            trap_q   <= 1'b0;
        end else begin
            trap_q <= 1'b0;
            if (state_q == st_normal && has_exc) begin
                state_q <= st_trap;
                trap_q  <= 1'b1;
            end else if (state_q == st_trap || has_mis) begin
                squash_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (has_exc) begin
            epc_q   <= exc_pc;
            cause_q <= i_req_cause;
        end
        if (state_q == st_trap) begin
            sq_pc_q     <= i_trap_vec;
            sq_taken_q  <= 1'b0;
            sq_branch_q <= 1'b0;
        end else if (has_mis) begin
            sq_pc_q     <= i_req_npc;
            sq_taken_q  <= i_req_taken;
            sq_branch_q <= 1'b1;
        end
    end

    assign o_stall                = busy;
    assign o_flush                = squash_q;
    assign o_trap_vld             = trap_q;
    assign o_trap_epc             = epc_q;
    assign o_trap_cause           = cause_q;
    assign o_squash_vld           = squash_q;
    assign o_squash_pc            = sq_pc_q;
    assign o_squash_taken         = sq_taken_q;
    assign o_squash_due_to_branch = sq_branch_q;

    // the held request names one entry, so at most one window slot hits it
    a_single_match: assert property (@(posedge clk) disable iff (rst)
        $onehot0(match));

endmodule

// ==== src/squash_tracker.sv ====
`timescale 1ns/1ps

module squash_tracker #(
    parameter int DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_flush,
    input  logic                        i_br_vld,
    input  logic [$clog2(DEPTH):0]      i_br_idx,
    input  logic [rob_pkg::XLEN-1:0]    i_br_npc,
    input  logic                        i_br_taken,
    input  logic                        i_exc_vld,
    input  logic [$clog2(DEPTH):0]      i_exc_idx,
    input  logic [rob_pkg::CAUSE_W-1:0] i_exc_cause,
    rob_head_if.observer                head,
    output rob_pkg::squash_kind_e       o_req_kind,
    output logic [$clog2(DEPTH):0]      o_req_idx,
    output logic [rob_pkg::XLEN-1:0]    o_req_npc,
    output logic                        o_req_taken,
    output logic [rob_pkg::CAUSE_W-1:0] o_req_cause
);

    localparam int IDX_W = $clog2(DEPTH) + 1;

    rob_pkg::squash_kind_e       kind_q;
    logic [IDX_W-1:0]            idx_q;
    logic [rob_pkg::XLEN-1:0]    npc_q;
    logic                        taken_q;
    logic [rob_pkg::CAUSE_W-1:0] cause_q;

    logic [IDX_W-1:0] age_br;
    logic [IDX_W-1:0] age_exc;
    logic [IDX_W-1:0] age_req;
    logic [IDX_W-1:0] cand_age;
    logic [IDX_W-1:0] cand_idx;
    logic             take_exc;
    logic             cand_vld;
    logic             replace;

    // age is the distance from the oldest live entry, wrap bit included
    assign age_br  = i_br_idx - head.head_idx[0];
    assign age_exc = i_exc_idx - head.head_idx[0];
    assign age_req = idx_q - head.head_idx[0];

    // pick the older of the two writebacks first
    assign take_exc = i_exc_vld && (!i_br_vld || age_exc < age_br);
    assign cand_vld = i_exc_vld || i_br_vld;
    assign cand_idx = take_exc ? i_exc_idx : i_br_idx;
    assign cand_age = take_exc ? age_exc : age_br;

    assign replace = cand_vld && (kind_q == rob_pkg::sq_none || cand_age < age_req);

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            kind_q <= rob_pkg::sq_none;
        end else if (replace) begin
            kind_q <= take_exc ? rob_pkg::sq_except : rob_pkg::sq_mispred;
        end
    end

    always_ff @(posedge clk) begin
        if (replace) begin
            idx_q   <= cand_idx;
            npc_q   <= i_br_npc;
            taken_q <= i_br_taken;
            cause_q <= i_exc_cause;
        end
    end

    assign o_req_kind  = kind_q;
    assign o_req_idx   = idx_q;
    assign o_req_npc   = npc_q;
    assign o_req_taken = taken_q;
    assign o_req_cause = cause_q;

endmodule

// ==== src/rob_queue.sv ====
`timescale 1ns/1ps

module rob_queue #(
    parameter int  DEPTH        = 16,
    parameter int  RENAME_WIDTH = 2,
    parameter int  COMPLETE_NUM = 3,
    parameter int  COMMIT_WIDTH = 2,
    parameter type payload_t    = rob_pkg::rob_entry_t
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_flush,
    input  logic                    i_enq_vld,
    input  logic [RENAME_WIDTH-1:0] i_enq_req,
    input  payload_t                i_enq_entry [RENAME_WIDTH],
    input  logic                    i_stall,
    output logic                    o_can_enq,
    output logic [$clog2(DEPTH):0]  o_alloc_idx [RENAME_WIDTH],
    input  logic [COMPLETE_NUM-1:0] i_fu_finished,
    input  logic [$clog2(DEPTH):0]  i_fu_idx [COMPLETE_NUM],
    rob_head_if.queue_side          head
);

    // DEPTH is a power of two and the top index bit is the wrap bit
    localparam int PTR_W = $clog2(DEPTH);
    localparam int IDX_W = PTR_W + 1;

    payload_t                mem [DEPTH];
    logic [DEPTH-1:0]        vld_q;
    logic [DEPTH-1:0]        done_q;
    logic [IDX_W-1:0]        head_q;
    logic [IDX_W-1:0]        tail_q;
    logic [IDX_W-1:0]        used;
    logic [IDX_W-1:0]        n_enq;
    logic [IDX_W-1:0]        n_ret;
    logic                    enq_fire;
    logic [IDX_W-1:0]        win_idx [COMMIT_WIDTH];
    logic [COMMIT_WIDTH-1:0] win_vld;

    assign used      = tail_q - head_q;
    assign o_can_enq = !i_stall && (used <= IDX_W'(DEPTH - RENAME_WIDTH));
    assign enq_fire  = i_enq_vld && o_can_enq;

    for (genvar k = 0; k < RENAME_WIDTH; k++) begin : g_alloc
        assign o_alloc_idx[k] = tail_q + IDX_W'(k);
    end

    // oldest COMMIT_WIDTH slots with data read straight from the store
    for (genvar k = 0; k < COMMIT_WIDTH; k++) begin : g_win
        assign win_idx[k]        = head_q + IDX_W'(k);
        assign head.head_idx[k]  = win_idx[k];
        assign head.head_data[k] = mem[win_idx[k][PTR_W-1:0]];
    end

    always_comb begin
        logic chain;
        chain = 1'b1;
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            // a slot is ready only behind ready slots
            chain      = chain && vld_q[win_idx[k][PTR_W-1:0]]
                               && done_q[win_idx[k][PTR_W-1:0]];
            win_vld[k] = chain;
        end
    end

    assign head.head_vld = win_vld;

    always_comb begin
        n_enq = '0;
        n_ret = '0;
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            n_enq = n_enq + IDX_W'(i_enq_req[k]);
        end
        for (int k = 0; k < COMMIT_WIDTH; k++) begin
            n_ret = n_ret + IDX_W'(head.retire[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            head_q <= '0;
            tail_q <= '0;
            vld_q  <= '0;
            done_q <= '0;
        end else begin
            for (int k = 0; k < COMMIT_WIDTH; k++) begin
                if (head.retire[k]) begin
                    vld_q[win_idx[k][PTR_W-1:0]] <= 1'b0;
                end
            end
            if (enq_fire) begin
                for (int k = 0; k < RENAME_WIDTH; k++) begin
                    if (i_enq_req[k]) begin
                        vld_q[o_alloc_idx[k][PTR_W-1:0]]  <= 1'b1;
                        done_q[o_alloc_idx[k][PTR_W-1:0]] <= i_enq_entry[k].done_on_insert;
                    end
                end
                tail_q <= tail_q + n_enq;
            end
            for (int k = 0; k < COMPLETE_NUM; k++) begin
                if (i_fu_finished[k]) begin
                    done_q[i_fu_idx[k][PTR_W-1:0]] <= 1'b1;
                end
            end
            head_q <= head_q + n_ret;
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < RENAME_WIDTH; k++) begin
            if (enq_fire && i_enq_req[k]) begin
                mem[o_alloc_idx[k][PTR_W-1:0]] <= i_enq_entry[k];
            end
        end
    end

    // lanes fill from lane 0 upward
    a_enq_contig: assert property (@(posedge clk) disable iff (rst)
        i_enq_vld |-> ((i_enq_req & (i_enq_req + 1'b1)) == '0));

    // an accepted insert never lands on a live entry
    for (genvar k = 0; k < RENAME_WIDTH; k++) begin : g_chk_enq
        a_enq_free_slot: assert property (@(posedge clk) disable iff (rst)
            enq_fire && i_enq_req[k] |-> !vld_q[o_alloc_idx[k][PTR_W-1:0]]);
    end

    for (genvar k = 0; k < COMPLETE_NUM; k++) begin : g_chk_fu
        a_fu_idx_live: assert property (@(posedge clk) disable iff (rst)
            i_fu_finished[k] |-> vld_q[i_fu_idx[k][PTR_W-1:0]]);
    end

endmodule

// ==== src/rob_head_if.sv ====
`timescale 1ns/1ps

interface rob_head_if #(
    parameter int  COMMIT_WIDTH = 2,
    parameter int  DEPTH        = 16,
    parameter type payload_t    = logic
);

    // rob index carries one extra wrap bit
    localparam int IDX_W = $clog2(DEPTH) + 1;

    logic [COMMIT_WIDTH-1:0] head_vld;
    logic [IDX_W-1:0]        head_idx [COMMIT_WIDTH];
    payload_t                head_data [COMMIT_WIDTH];
    logic [COMMIT_WIDTH-1:0] retire;

    modport queue_side (
        output head_vld,
        output head_idx,
        output head_data,
        input  retire
    );

    modport ctrl_side (
        input  head_vld,
        input  head_idx,
        input  head_data,
        output retire
    );

    // age reference only
    modport observer (
        input  head_idx
    );

endinterface

// ==== src/rob_pkg.sv ====
package rob_pkg;

    localparam int XLEN    = 32;
    localparam int PREG_W  = 6;
    localparam int CAUSE_W = 4;

    // one instruction as held in the reorder buffer
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic              has_rd;
        logic [4:0]        lrd;
        logic [PREG_W-1:0] prd;
        logic [PREG_W-1:0] prev_prd;
        // moves are finished by rename already
        logic              done_on_insert;
    } rob_entry_t;

    // retire record handed back to rename
    typedef struct packed {
        logic              has_rd;
        logic [4:0]        lrd;
        logic [PREG_W-1:0] prd;
        logic [PREG_W-1:0] prev_prd;
    } commit_info_t;

    typedef enum logic [1:0] {
        sq_none    = 2'd0,
        sq_mispred = 2'd1,
        sq_except  = 2'd2
    } squash_kind_e;

endpackage
